// ==== Bender.yml ====
package:
  name: ldpc_decoder

sources:
  - include_dirs:
      - common
    files:
      - common/ldpc_pkg.sv
      - ldpc_ctrl/ldpc_ctrl.sv
      - logic/ldpc_cnu.sv
      - logic/ldpc_vnu.sv
      - logic/ldpc_decoder.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_ldpc_decoder.sv

// ==== common/ldpc_params.svh ====
// code size, widths and parity-check row masks, included by every ldpc rtl file
`ifndef LDPC_PARAMS_SVH
`define LDPC_PARAMS_SVH

// channel llr and edge message width, signed
`define LDPC_LLR_W 6
// posterior sum width, holds llr plus two check messages
`define LDPC_POST_W 8

// regular (2,4) code
`define LDPC_N_VAR 8
`define LDPC_N_CHK 4

// max_iter and iteration counter width
`define LDPC_ITER_W 5

// row masks, bit i set when variable vi takes part in the check
`define LDPC_H_ROW0 8'h0f
`define LDPC_H_ROW1 8'hf0
`define LDPC_H_ROW2 8'h55
`define LDPC_H_ROW3 8'haa

`endif

// ==== common/ldpc_pkg.sv ====
// shared phase encoding and message/result structs for the ldpc decoder and its testbench
`include "ldpc_params.svh"
`default_nettype none

package ldpc_pkg;

    // controller phases
    typedef enum logic [2:0]
    {
        PH_IDLE = 3'd0,
        PH_LOAD = 3'd1,
        PH_CNU  = 3'd2,
        PH_VNU  = 3'd3,
        PH_OUT  = 3'd4
    } ldpc_phase_t;

    // one sequencing step broadcast to both node units
    // idx is the variable in load/vnu, the row in cnu
    typedef struct packed {
        ldpc_phase_t phase;
        logic [2:0]  idx;
        logic        valid;
    } ldpc_step_t;

    // four edges of one check row, m0 is the lowest variable of the row
    typedef struct packed {
        logic [`LDPC_LLR_W-1:0] m3;
        logic [`LDPC_LLR_W-1:0] m2;
        logic [`LDPC_LLR_W-1:0] m1;
        logic [`LDPC_LLR_W-1:0] m0;
    } ldpc_row_msg_t;

    // all 16 edges, indexed by row
    typedef ldpc_row_msg_t [3:0] ldpc_edge_bus_t;

    // decode outcome presented with done
    typedef struct packed {
        logic [`LDPC_N_VAR-1:0]  word;
        logic [`LDPC_ITER_W-1:0] iters;
        logic                    converged;
    } ldpc_result_t;

endpackage

`default_nettype wire

// ==== ldpc_ctrl/ldpc_ctrl.sv ====
// phase fsm, counters and result register that the decoder top instantiates once
`include "ldpc_params.svh"
`timescale 1ns/10ps
`default_nettype none

module ldpc_ctrl (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     start,
    input  wire logic                     llr_valid,
    input  wire logic [`LDPC_ITER_W-1:0]  max_iter,
    input  wire logic [`LDPC_N_VAR-1:0]   hard,
    input  wire logic                     parity_fail,
    output ldpc_pkg::ldpc_step_t          step,
    output logic                          busy,
    output logic                          done,
    output ldpc_pkg::ldpc_result_t        result
);

    ldpc_pkg::ldpc_phase_t     phase_q;
    logic [2:0]                idx_q;
    // evaluation cycle after the last vnu step
    logic                      eval_q;
    logic [`LDPC_ITER_W-1:0]   iter_q;
    logic [`LDPC_ITER_W-1:0]   max_q;
    logic                      last_load;
    logic                      last_cnu;
    logic                      last_vnu;
    logic                      stop;

    assign last_load = llr_valid && (idx_q == 3'(`LDPC_N_VAR - 1));
    assign last_cnu  = (idx_q == 3'(`LDPC_N_CHK - 1));
    assign last_vnu  = (idx_q == 3'(`LDPC_N_VAR - 1));
    // converged or iteration budget used up
    assign stop      = !parity_fail || (iter_q == max_q);

    assign busy = (phase_q != ldpc_pkg::PH_IDLE);
    assign done = (phase_q == ldpc_pkg::PH_OUT);

    // step word seen by both node units
    always_comb
    begin
        step.phase = phase_q;
        step.idx   = idx_q;
        case (phase_q)
            ldpc_pkg::PH_LOAD: step.valid = llr_valid;
            ldpc_pkg::PH_CNU:  step.valid = 1'b1;
            // no step during evaluation
            ldpc_pkg::PH_VNU:  step.valid = !eval_q;
            default:           step.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            phase_q <= ldpc_pkg::PH_IDLE;
            idx_q   <= '0;
            eval_q  <= 1'b0;
            iter_q  <= '0;
            max_q   <= '0;
            result  <= '0;
        end
        else
        begin
            case (phase_q)
                ldpc_pkg::PH_IDLE:
                    if (start)
                    begin
                        phase_q <= ldpc_pkg::PH_LOAD;
                        idx_q   <= '0;
                        iter_q  <= '0;
                        max_q   <= max_iter;
                    end
                ldpc_pkg::PH_LOAD:
                    // index wraps to 0 after v7 and so starts cnu at row 0
                    if (llr_valid)
                    begin
                        idx_q <= idx_q + 3'd1;
                        if (last_load)
                        begin
                            phase_q <= ldpc_pkg::PH_CNU;
                            iter_q  <= iter_q + 1'b1;
                        end
                    end
                ldpc_pkg::PH_CNU:
                    if (last_cnu)
                    begin
                        phase_q <= ldpc_pkg::PH_VNU;
                        idx_q   <= '0;
                    end
                    else
                        idx_q <= idx_q + 3'd1;
                ldpc_pkg::PH_VNU:
                    if (eval_q)
                    begin
                        eval_q <= 1'b0;
                        idx_q  <= '0;
                        if (stop)
                        begin
                            // captured here so result is valid while done is high
                            phase_q          <= ldpc_pkg::PH_OUT;
                            result.word      <= hard;
                            result.iters     <= iter_q;
                            result.converged <= !parity_fail;
                        end
                        else
                        begin
                            // parity error loops back for another iteration
                            phase_q <= ldpc_pkg::PH_CNU;
                            iter_q  <= iter_q + 1'b1;
                        end
                    end
                    else
                    begin
                        idx_q <= idx_q + 3'd1;
                        if (last_vnu)
                            eval_q <= 1'b1;
                    end
                default:
                    phase_q <= ldpc_pkg::PH_IDLE;
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done);

    a_cnu_row: assert property (@(posedge clk) disable iff (!reset_n)
        (step.valid && step.phase == ldpc_pkg::PH_CNU) |-> (step.idx < `LDPC_N_CHK));

    // start while busy neither reopens load nor moves the load index
    a_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (start && busy)
            |=> $stable(max_q)
                && (phase_q != ldpc_pkg::PH_LOAD || $past(phase_q) == ldpc_pkg::PH_LOAD)
                && ($past(phase_q) != ldpc_pkg::PH_LOAD || $past(llr_valid)
                    || $stable(idx_q)));

endmodule

`default_nettype wire

// ==== logic/ldpc_cnu.sv ====
// check-node unit: min-sum update of one row per cnu step, holds the check-to-variable store
`include "ldpc_params.svh"
`timescale 1ns/10ps
`default_nettype none

module ldpc_cnu (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire ldpc_pkg::ldpc_step_t     step,
    input  wire ldpc_pkg::ldpc_edge_bus_t v2c,
    output ldpc_pkg::ldpc_edge_bus_t      c2v
);

    localparam int W       = `LDPC_LLR_W;
    // symmetric llr range, -32 never leaves this unit
    localparam int MAG_MAX = (1 << (W - 1)) - 1;

    logic [3:0][W-1:0]                  in_msg;
    logic [3:0][W-1:0]                  out_msg;
    // W bits unsigned, room for magnitude 32
    logic [3:0][W-1:0]                  mag;
    logic [3:0]                         sgn;
    logic [`LDPC_N_CHK-1:0][3:0][W-1:0] store_q;
    logic                               row_hit;
    logic                               clear;

    assign row_hit = step.valid && (step.phase == ldpc_pkg::PH_CNU);
    // first llr of a new block wipes the previous decode
    assign clear   = step.valid && (step.phase == ldpc_pkg::PH_LOAD) && (step.idx == 3'd0);

    // row selected by the step index
    assign in_msg = v2c[step.idx[1:0]];

    // sign and magnitude of each incoming edge
    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            sgn[k] = in_msg[k][W-1];
            mag[k] = in_msg[k][W-1] ? -in_msg[k] : in_msg[k];
        end
    end

    // extrinsic min-sum, each edge sees only the other three
    always_comb
    begin
        logic [W-1:0] m;
        logic         s;
        for (int e = 0; e < 4; e++)
        begin
            m = {W{1'b1}};
            s = 1'b0;
            for (int k = 0; k < 4; k++)
            begin
                if (k != e)
                begin
                    if (mag[k] < m)
                        m = mag[k];
                    s = s ^ sgn[k];
                end
            end
            if (m > MAG_MAX)
                m = MAG_MAX[W-1:0];
            out_msg[e] = s ? -m : m;
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            store_q <= '0;
        else if (clear)
            store_q <= '0;
        else if (row_hit)
            store_q[step.idx[1:0]] <= out_msg;
    end

    assign c2v = store_q;

    a_row_range: assert property (@(posedge clk) disable iff (!reset_n)
        row_hit |-> (step.idx < `LDPC_N_CHK));

endmodule

`default_nettype wire

// ==== logic/ldpc_decoder.sv ====
// ldpc decoder top: controller plus check-node and variable-node units
`include "ldpc_params.svh"
`timescale 1ns/10ps
`default_nettype none

module ldpc_decoder (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     start,
    input  wire logic                     llr_valid,
    input  wire logic [`LDPC_LLR_W-1:0]   llr_in,
    input  wire logic [`LDPC_ITER_W-1:0]  max_iter,
    output logic                          busy,
    output logic                          done,
    output ldpc_pkg::ldpc_result_t        result
);

    ldpc_pkg::ldpc_step_t     step;
    ldpc_pkg::ldpc_edge_bus_t v2c;
    ldpc_pkg::ldpc_edge_bus_t c2v;
    logic [`LDPC_N_VAR-1:0]   hard;
    logic                     parity_fail;

    ldpc_ctrl ctrl_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .llr_valid   (llr_valid),
        .max_iter    (max_iter),
        .hard        (hard),
        .parity_fail (parity_fail),
        .step        (step),
        .busy        (busy),
        .done        (done),
        .result      (result)
    );

    ldpc_cnu cnu_i (
        .clk     (clk),
        .reset_n (reset_n),
        .step    (step),
        .v2c     (v2c),
        .c2v     (c2v)
    );

    // channel llrs go straight in, the load step says where
    ldpc_vnu vnu_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .step        (step),
        .llr_in      (llr_in),
        .c2v         (c2v),
        .v2c         (v2c),
        .hard        (hard),
        .parity_fail (parity_fail)
    );

endmodule

`default_nettype wire

// ==== logic/ldpc_vnu.sv ====
// variable-node unit: channel llrs, posterior and outgoing messages, hard bits and parity check
`include "ldpc_params.svh"
`timescale 1ns/10ps
`default_nettype none

module ldpc_vnu (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire ldpc_pkg::ldpc_step_t     step,
    input  wire logic [`LDPC_LLR_W-1:0]   llr_in,
    input  wire ldpc_pkg::ldpc_edge_bus_t c2v,
    output ldpc_pkg::ldpc_edge_bus_t      v2c,
    output logic [`LDPC_N_VAR-1:0]        hard,
    output logic                          parity_fail
);

    localparam int W       = `LDPC_LLR_W;
    localparam int PW      = `LDPC_POST_W;
    localparam int NV      = `LDPC_N_VAR;
    localparam int MAG_MAX = (1 << (W - 1)) - 1;

    logic [NV-1:0][W-1:0]   chan_q;
    logic [3:0][3:0][W-1:0] v2c_q;
    logic [3:0][3:0][W-1:0] c2v_a;
    // the two edges of the current variable, row and slot in that row
    logic [1:0]             row_a;
    logic [1:0]             pos_a;
    logic [1:0]             row_b;
    logic [1:0]             pos_b;
    logic signed [PW-1:0]   chan_x;
    logic signed [PW-1:0]   msg_a;
    logic signed [PW-1:0]   msg_b;
    logic signed [PW-1:0]   post;
    logic [NV-1:0]          hard_nx;
    logic                   load_hit;
    logic                   vnu_hit;

    function automatic logic [W-1:0] sat_llr(input logic signed [PW-1:0] x);
        if (x > MAG_MAX)
            return W'(MAG_MAX);
        else if (x < -MAG_MAX)
            return W'(-MAG_MAX);
        else
            return x[W-1:0];
    endfunction

    assign load_hit = step.valid && (step.phase == ldpc_pkg::PH_LOAD);
    assign vnu_hit  = step.valid && (step.phase == ldpc_pkg::PH_VNU);

    // rows 0/1 hold v0-v3 and v4-v7, rows 2/3 hold even and odd variables
    assign row_a = {1'b0, step.idx[2]};
    assign pos_a = step.idx[1:0];
    assign row_b = {1'b1, step.idx[0]};
    assign pos_b = step.idx[2:1];

    assign c2v_a = c2v;

    // sign-extend to posterior width
    assign chan_x = {{(PW - W){chan_q[step.idx][W-1]}}, chan_q[step.idx]};
    assign msg_a  = {{(PW - W){c2v_a[row_a][pos_a][W-1]}}, c2v_a[row_a][pos_a]};
    assign msg_b  = {{(PW - W){c2v_a[row_b][pos_b][W-1]}}, c2v_a[row_b][pos_b]};
    assign post   = chan_x + msg_a + msg_b;

    // hard word including the bit written this cycle
    always_comb
    begin
        hard_nx = hard;
        hard_nx[step.idx] = post[PW-1];
    end

    // message and llr store
    always_ff @(posedge clk)
    begin
        if (load_hit)
        begin
            chan_q[step.idx]      <= llr_in;
            v2c_q[row_a][pos_a]   <= llr_in;
            v2c_q[row_b][pos_b]   <= llr_in;
        end
        else if (vnu_hit)
        begin
            // extrinsic: drop the edge's own incoming message
            v2c_q[row_a][pos_a]   <= sat_llr(post - msg_a);
            v2c_q[row_b][pos_b]   <= sat_llr(post - msg_b);
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            hard        <= '0;
            parity_fail <= 1'b0;
        end
        else if (vnu_hit)
        begin
            hard[step.idx] <= post[PW-1];
            // full word known at v7, ready for the evaluation cycle
            if (step.idx == 3'(NV - 1))
                parity_fail <= (^(hard_nx & `LDPC_H_ROW0)) | (^(hard_nx & `LDPC_H_ROW1))
                             | (^(hard_nx & `LDPC_H_ROW2)) | (^(hard_nx & `LDPC_H_ROW3));
        end
    end

    assign v2c = v2c_q;

    a_v2c_known: assert property (@(posedge clk) disable iff (!reset_n)
        (step.valid && step.phase == ldpc_pkg::PH_CNU) |-> !$isunknown(v2c));

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/ldpc_pkg.sv
ldpc_ctrl/ldpc_ctrl.sv
logic/ldpc_cnu.sv
logic/ldpc_vnu.sv
logic/ldpc_decoder.sv
testbench/tb_ldpc_decoder.sv

// ==== testbench/ldpc_stim.txt ====
# columns, all hex: max_iter llr_v0 .. llr_v7 exp_word exp_iters exp_converged
# llrs are 6-bit two's complement, every vector is listed twice in a row
05 0c 07 0a 1f 03 0e 09 05 00 01 1
05 0c 07 0a 1f 03 0e 09 05 00 01 1
03 21 1f 1f 1f 1f 1f 1f 1f 04 03 0
03 21 1f 1f 1f 1f 1f 1f 1f 04 03 0
05 37 37 37 37 09 3d 09 09 0f 01 1
05 37 37 37 37 09 3d 09 09 0f 01 1
05 08 34 06 37 31 0b 39 0d 5a 01 1
05 08 34 06 37 31 0b 39 0d 5a 01 1
04 21 1f 1f 1f 1f 1f 1f 1f 01 04 0
04 21 1f 1f 1f 1f 1f 1f 1f 01 04 0
05 0a 0a 3e 0a 0a 0a 0a 0a 00 01 1
05 0a 0a 3e 0a 0a 0a 0a 0a 00 01 1

// ==== testbench/tb_ldpc_decoder.sv ====
// self-checking testbench that replays the stimulus file vectors through the ldpc decoder
`include "ldpc_params.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_ldpc_decoder;

    localparam int CLK_PERIOD  = 8;
    // cycles per test for a load with gaps and the full iteration budget
    localparam int TEST_CYCLES = 20 + 31 * 13;

    logic                    clk;
    logic                    reset_n;
    logic                    start;
    logic                    llr_valid;
    logic [`LDPC_LLR_W-1:0]  llr_in;
    logic [`LDPC_ITER_W-1:0] max_iter;
    logic                    busy;
    logic                    done;
    ldpc_pkg::ldpc_result_t  result;

    // one entry per stimulus file line
    logic [`LDPC_ITER_W-1:0]                 vec_max[$];
    logic [`LDPC_N_VAR-1:0][`LDPC_LLR_W-1:0] vec_llr[$];
    ldpc_pkg::ldpc_result_t                  vec_exp[$];
    bit                                      vectors_read;
    int                                      errors;
    int                                      checks;
    integer                                  seed;

    ldpc_decoder dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .llr_valid (llr_valid),
        .llr_in    (llr_in),
        .max_iter  (max_iter),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bit r set when check row r sees odd parity
    function automatic logic [3:0] row_parity(input logic [`LDPC_N_VAR-1:0] word);
        row_parity[0] = ^(word & `LDPC_H_ROW0);
        row_parity[1] = ^(word & `LDPC_H_ROW1);
        row_parity[2] = ^(word & `LDPC_H_ROW2);
        row_parity[3] = ^(word & `LDPC_H_ROW3);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic read_vectors();
        int                                      fd;
        int                                      n;
        int                                      m;
        int                                      w;
        int                                      it;
        int                                      cv;
        int                                      l[8];
        string                                   line;
        ldpc_pkg::ldpc_result_t                  exp_r;
        logic [`LDPC_N_VAR-1:0][`LDPC_LLR_W-1:0] llrs;
        fd = $fopen("testbench/ldpc_stim.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("cannot open the stimulus file testbench/ldpc_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        m, l[0], l[1], l[2], l[3], l[4], l[5], l[6], l[7], w, it, cv);
            if (n != 12)
            begin
                errors++;
                $display("malformed stimulus line: %s", line);
                continue;
            end
            for (int k = 0; k < `LDPC_N_VAR; k++)
                llrs[k] = l[k][`LDPC_LLR_W-1:0];
            exp_r.word      = w[`LDPC_N_VAR-1:0];
            exp_r.iters     = it[`LDPC_ITER_W-1:0];
            exp_r.converged = cv[0];
            vec_max.push_back(m[`LDPC_ITER_W-1:0]);
            vec_llr.push_back(llrs);
            vec_exp.push_back(exp_r);
        end
        $fclose(fd);
    endtask

    task automatic run_decode(input int t);
        int                     gap;
        ldpc_pkg::ldpc_result_t exp_r;
        exp_r = vec_exp[t];
        @(posedge clk);
        start    <= 1'b1;
        max_iter <= vec_max[t];
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (!busy)
        begin
            errors++;
            $display("busy did not rise after start in test %0d", t);
        end
        // v0 first with random idle cycles between strobes
        for (int i = 0; i < `LDPC_N_VAR; i++)
        begin
            gap = $unsigned($random(seed)) % 2;
            repeat (gap)
            begin
                @(posedge clk);
                llr_valid <= 1'b0;
                start     <= 1'b0;
            end
            @(posedge clk);
            llr_valid <= 1'b1;
            llr_in    <= vec_llr[t][i];
            // second copy of each vector pair sees a stray start alongside v3
            start     <= (t % 2 == 1) && (i == 3);
        end
        @(posedge clk);
        llr_valid <= 1'b0;
        // and another stray start once the decode runs
        if (t % 2 == 1)
            start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // busy has to hold until done
        @(negedge clk);
        while (!done)
        begin
            if (!busy)
            begin
                errors++;
                $display("busy dropped before done in test %0d", t);
            end
            @(negedge clk);
        end
        check_value("result.word", exp_r.word, result.word);
        check_value("result.iters", exp_r.iters, result.iters);
        check_value("result.converged", exp_r.converged, result.converged);
        // converged exactly when the returned word meets all four checks
        if ((row_parity(result.word) == 4'd0) != result.converged)
        begin
            errors++;
            $display("converged flag disagrees with the row parity of the word in test %0d", t);
        end
        @(negedge clk);
        check_value("done", 0, done);
        check_value("busy", 0, busy);
    endtask

    initial
    begin
        errors    = 0;
        checks    = 0;
        seed      = 32'h87fc3aaa;
        reset_n   = 1'b0;
        start     = 1'b0;
        llr_valid = 1'b0;
        llr_in    = '0;
        max_iter  = '0;
        read_vectors();
        vectors_read = 1'b1;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("result", 0, result);
        if (vec_max.size() == 0)
        begin
            errors++;
            $display("no test vectors were read");
        end
        for (int t = 0; t < vec_max.size(); t++)
            run_decode(t);
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog sized from the number of vectors
    initial
    begin
        wait (vectors_read);
        #((vec_max.size() * TEST_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the decoder did not finish all tests in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
